/* logic/core_defines.svh */
// Width, opcode and latency macros for the execution slice
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and tag widths
`define XLEN       32
`define ROB_TAG_W  6
`define PREG_W     8

// Cycles from issue to completion
`define ALU_LAT    4
`define MUL_LAT    5

// RV32 major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_BRANCH  7'b1100011

`endif

/* logic/core_pkg.sv */
// Instruction word union, issue packet, decoded op, completion and redirect types
`default_nettype none

`include "core_defines.svh"

package core_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // One word, three views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
    } inst_word_u;

    typedef struct packed {
        logic                  valid;
        inst_word_u            inst;
        logic [`XLEN-1:0]      pc;
        logic [`ROB_TAG_W-1:0] rob_tag;
        logic [`PREG_W-1:0]    prd;
        logic [`XLEN-1:0]      rs1_val;
        logic [`XLEN-1:0]      rs2_val;
    } issue_pkt_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_ILLEGAL
    } alu_op_e;

    typedef struct packed {
        logic                  valid;
        alu_op_e               op;
        logic                  is_mul;
        logic                  is_branch;
        logic                  illegal;
        logic [`XLEN-1:0]      a;
        logic [`XLEN-1:0]      b;          // rs2 value or I immediate
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      br_offset;
        logic [`ROB_TAG_W-1:0] rob_tag;
        logic [`PREG_W-1:0]    prd;
    } dec_op_t;

    typedef struct packed {
        logic                  valid;
        logic [`ROB_TAG_W-1:0] rob_tag;
        logic [`PREG_W-1:0]    prd;
        logic [`XLEN-1:0]      value;
        logic                  illegal;
    } cpl_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

/* logic/ifid_stage.sv */
// Front pipeline register with flush and the ROB flush pulse
`timescale 1ns/1ps
`default_nettype none

module ifid_stage
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  issue_pkt_t issue,
    output issue_pkt_t if_id,
    output logic       rob_flush
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_id     <= '0;
            rob_flush <= 1'b0;
        end else if (flush) begin
            if_id     <= '0;   // Drop the wrong-path op
            rob_flush <= 1'b1;
        end else begin
            if_id     <= issue;
            rob_flush <= 1'b0;
        end
    end

    // A redirect lasts one cycle, so the ROB flush must as well
    property p_rob_flush_single;
        @(posedge clk) disable iff (reset)
        rob_flush |=> !rob_flush;
    endproperty

    a_rob_flush_single: assert property (p_rob_flush_single)
        else $error("rob_flush held for two cycles");

endmodule

`default_nettype wire

/* logic/inst_decode.sv */
// Instruction decoder and ID/EX register
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module inst_decode
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  issue_pkt_t if_id,
    output dec_op_t    id_ex
);

    inst_word_u       inst;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] off_b;
    alu_op_e          op;
    logic             is_mul;
    logic             is_branch;
    dec_op_t          dec;

    assign inst  = if_id.inst;
    assign imm_i = {{(`XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
    assign off_b = {{(`XLEN-13){inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};

    always_comb begin
        op        = ALU_ILLEGAL;
        is_mul    = 1'b0;
        is_branch = 1'b0;
        case (inst.r.opcode)
            `OPC_OP: begin
                case ({inst.r.funct7, inst.r.funct3})
                    {7'b0000000, 3'b000}: op = ALU_ADD;
                    {7'b0100000, 3'b000}: op = ALU_SUB;
                    {7'b0000000, 3'b111}: op = ALU_AND;
                    {7'b0000000, 3'b110}: op = ALU_OR;
                    {7'b0000000, 3'b100}: op = ALU_XOR;
                    {7'b0000000, 3'b010}: op = ALU_SLT;
                    {7'b0000000, 3'b001}: op = ALU_SLL;
                    {7'b0000000, 3'b101}: op = ALU_SRL;
                    {7'b0100000, 3'b101}: op = ALU_SRA;
                    {7'b0000001, 3'b000}: begin
                        op     = ALU_ADD;   // Unused by the multiplier
                        is_mul = 1'b1;
                    end
                    default: op = ALU_ILLEGAL;
                endcase
            end
            `OPC_OP_IMM: begin
                case (inst.i.funct3)
                    3'b000:  op = ALU_ADD;
                    3'b111:  op = ALU_AND;
                    3'b110:  op = ALU_OR;
                    3'b100:  op = ALU_XOR;
                    3'b010:  op = ALU_SLT;
                    default: op = ALU_ILLEGAL;
                endcase
            end
            `OPC_BRANCH: begin
                is_branch = 1'b1;
                case (inst.b.funct3)
                    3'b000:  op = ALU_BEQ;
                    3'b001:  op = ALU_BNE;
                    3'b100:  op = ALU_BLT;
                    3'b101:  op = ALU_BGE;
                    default: begin
                        op        = ALU_ILLEGAL;
                        is_branch = 1'b0;
                    end
                endcase
            end
            default: op = ALU_ILLEGAL;
        endcase
    end

    always_comb begin
        dec.valid     = if_id.valid;
        dec.op        = op;
        dec.is_mul    = is_mul;
        dec.is_branch = is_branch;
        dec.illegal   = (op == ALU_ILLEGAL);
        dec.a         = if_id.rs1_val;
        dec.b         = (inst.i.opcode == `OPC_OP_IMM) ? imm_i : if_id.rs2_val;
        dec.pc        = if_id.pc;
        dec.br_offset = off_b;
        dec.rob_tag   = if_id.rob_tag;
        dec.prd       = if_id.prd;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else if (flush) begin
            id_ex <= '0;
        end else begin
            id_ex <= dec;
        end
    end

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
// ALU, branch compare and two-stage multiplier with per-stage squash
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module exec_unit
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  dec_op_t   id_ex,
    output cpl_t      alu_res,
    output cpl_t      mul_res,
    output redirect_t br_res
);

    typedef struct packed {
        logic                  valid;
        logic [`ROB_TAG_W-1:0] rob_tag;
        logic [`PREG_W-1:0]    prd;
        logic [`XLEN-1:0]      p_lo;   // a * b[15:0]
        logic [15:0]           p_hi;   // a[15:0] * b[31:16], low half
    } mul_s1_t;

    logic [`XLEN-1:0] alu_value;
    logic             taken;
    mul_s1_t          mul_s1;

    always_comb begin
        alu_value = '0;
        taken     = 1'b0;
        case (id_ex.op)
            ALU_ADD: alu_value = id_ex.a + id_ex.b;
            ALU_SUB: alu_value = id_ex.a - id_ex.b;
            ALU_AND: alu_value = id_ex.a & id_ex.b;
            ALU_OR:  alu_value = id_ex.a | id_ex.b;
            ALU_XOR: alu_value = id_ex.a ^ id_ex.b;
            ALU_SLT: alu_value = {{(`XLEN-1){1'b0}}, $signed(id_ex.a) < $signed(id_ex.b)};
            ALU_SLL: alu_value = id_ex.a << id_ex.b[4:0];
            ALU_SRL: alu_value = id_ex.a >> id_ex.b[4:0];
            ALU_SRA: alu_value = $signed(id_ex.a) >>> id_ex.b[4:0];
            ALU_BEQ: taken = (id_ex.a == id_ex.b);
            ALU_BNE: taken = (id_ex.a != id_ex.b);
            ALU_BLT: taken = ($signed(id_ex.a) < $signed(id_ex.b));
            ALU_BGE: taken = ($signed(id_ex.a) >= $signed(id_ex.b));
            default: alu_value = '0;   // Illegal completes with zero
        endcase
    end

    // ALU and branch outputs
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_res <= '0;
            br_res  <= '0;
        end else if (flush) begin
            alu_res.valid <= 1'b0;
            br_res.valid  <= 1'b0;
        end else begin
            alu_res.valid   <= id_ex.valid & ~id_ex.is_mul;
            alu_res.rob_tag <= id_ex.rob_tag;
            alu_res.prd     <= id_ex.prd;
            alu_res.value   <= alu_value;
            alu_res.illegal <= id_ex.illegal;
            br_res.valid    <= id_ex.valid & id_ex.is_branch & taken;
            br_res.target   <= id_ex.pc + id_ex.br_offset;
        end
    end

    // Multiplier stage 1, partial products
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mul_s1 <= '0;
        end else if (flush) begin
            mul_s1.valid <= 1'b0;
        end else begin
            mul_s1.valid   <= id_ex.valid & id_ex.is_mul;
            mul_s1.rob_tag <= id_ex.rob_tag;
            mul_s1.prd     <= id_ex.prd;
            mul_s1.p_lo    <= id_ex.a * {16'b0, id_ex.b[15:0]};
            mul_s1.p_hi    <= id_ex.a[15:0] * id_ex.b[31:16];
        end
    end

    // Multiplier stage 2, low word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mul_res <= '0;
        end else if (flush) begin
            mul_res.valid <= 1'b0;
        end else begin
            mul_res.valid   <= mul_s1.valid;
            mul_res.rob_tag <= mul_s1.rob_tag;
            mul_res.prd     <= mul_s1.prd;
            mul_res.value   <= mul_s1.p_lo + {mul_s1.p_hi, 16'b0};
            mul_res.illegal <= 1'b0;
        end
    end

    // Ops enter one per cycle, so the two channels never carry the same op
    a_distinct_tags: assert property (@(posedge clk) disable iff (reset)
        (alu_res.valid && mul_res.valid) |-> (alu_res.rob_tag != mul_res.rob_tag))
        else $error("ALU and MUL results share ROB tag %0d", alu_res.rob_tag);

endmodule

`default_nettype wire

/* logic/result_stage.sv */
// EX/MEM result register with ALU and MUL completion channels and branch redirect
`timescale 1ns/1ps
`default_nettype none

module result_stage
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  cpl_t      alu_res,
    input  cpl_t      mul_res,
    input  redirect_t br_res,
    output cpl_t      alu_cpl,
    output cpl_t      mul_cpl,
    output redirect_t redirect
);

    // ALU channel, also carries branch and illegal completions
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_cpl <= '0;
        end else if (flush) begin
            alu_cpl.valid <= 1'b0;   // Younger op, squashed
        end else begin
            alu_cpl <= alu_res;
        end
    end

    // MUL channel
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mul_cpl <= '0;
        end else if (flush) begin
            mul_cpl.valid <= 1'b0;
        end else begin
            mul_cpl <= mul_res;
        end
    end

    // Taken branch becomes a one-cycle redirect
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            redirect <= '0;
        end else if (flush) begin
            redirect.valid <= 1'b0;
        end else begin
            redirect.valid  <= br_res.valid;
            redirect.target <= br_res.target;
        end
    end

    // flush is the redirect fed back, so a second taken branch behind
    // the first must be swallowed
    property p_redirect_single;
        @(posedge clk) disable iff (reset)
        redirect.valid |=> !redirect.valid;
    endproperty

    a_redirect_single: assert property (p_redirect_single)
        else $error("redirect held for two cycles, target %h", redirect.target);

endmodule

`default_nettype wire

/* logic/exec_slice_top.sv */
// Execution slice top level with redirect fed back as flush
`timescale 1ns/1ps
`default_nettype none

module exec_slice_top
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  issue_pkt_t issue,
    output cpl_t       alu_cpl,
    output cpl_t       mul_cpl,
    output redirect_t  redirect,
    output logic       rob_flush
);

    issue_pkt_t if_id;
    dec_op_t    id_ex;
    cpl_t       alu_res;
    cpl_t       mul_res;
    redirect_t  br_res;
    logic       flush;

    assign flush = redirect.valid;   // Squash all younger ops

    ifid_stage u_ifid (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .issue     (issue),
        .if_id     (if_id),
        .rob_flush (rob_flush)
    );

    inst_decode u_decode (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .if_id (if_id),
        .id_ex (id_ex)
    );

    exec_unit u_exec (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .id_ex   (id_ex),
        .alu_res (alu_res),
        .mul_res (mul_res),
        .br_res  (br_res)
    );

    result_stage u_result (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .alu_res  (alu_res),
        .mul_res  (mul_res),
        .br_res   (br_res),
        .alu_cpl  (alu_cpl),
        .mul_cpl  (mul_cpl),
        .redirect (redirect)
    );

endmodule

`default_nettype wire

/* bench/exec_slice_tb.sv */
// Testbench for the execution slice with case file, random ops, RV32 model and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module exec_slice_tb
    import core_pkg::*;
;

    typedef struct {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [7:0]  prd;
        logic [31:0] value;
        logic        redir;
        string       name;
    } case_t;

    typedef struct {
        int        due;
        bit        on_mul;
        cpl_t      cpl;
        redirect_t redir;
        string     name;
    } entry_t;

    logic       clk = 1'b0;
    logic       reset;
    issue_pkt_t issue;
    cpl_t       alu_cpl;
    cpl_t       mul_cpl;
    redirect_t  redirect;
    logic       rob_flush;

    case_t       cases[$];
    entry_t      pend[$];
    int          cyc = 0;
    int          squash_until = -1;
    int          last_redir = -10;
    bit          cases_loaded = 1'b0;
    logic [31:0] rnd = 32'h589f;

    exec_slice_top uut (
        .clk       (clk),
        .reset     (reset),
        .issue     (issue),
        .alu_cpl   (alu_cpl),
        .mul_cpl   (mul_cpl),
        .redirect  (redirect),
        .rob_flush (rob_flush)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // RV32 reference for the supported subset
    function automatic void model_op(input logic [31:0] inst, input logic [31:0] pc,
                                     input logic [31:0] a, input logic [31:0] b,
                                     output logic [31:0] value, output logic illegal,
                                     output logic is_mul, output logic [31:0] target);
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] imm;
        logic [31:0] off;
        opc = inst[6:0];
        f3 = inst[14:12];
        f7 = inst[31:25];
        imm = {{20{inst[31]}}, inst[31:20]};
        off = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        value = 32'h0;
        illegal = 1'b0;
        is_mul = 1'b0;
        target = pc + off;
        if (opc == `OPC_OP) begin
            if (f7 == 7'h01 && f3 == 3'd0) begin
                is_mul = 1'b1;
                value = a * b;
            end else if (f7 == 7'h00) begin
                case (f3)
                    3'd0: value = a + b;
                    3'd1: value = a << b[4:0];
                    3'd2: value = {31'b0, $signed(a) < $signed(b)};
                    3'd4: value = a ^ b;
                    3'd5: value = a >> b[4:0];
                    3'd6: value = a | b;
                    default: value = a & b;   // Only 3'd7 is left besides 3'd3
                endcase
                if (f3 == 3'd3) begin
                    value = 32'h0;
                    illegal = 1'b1;
                end
            end else if (f7 == 7'h20 && f3 == 3'd0) begin
                value = a - b;
            end else if (f7 == 7'h20 && f3 == 3'd5) begin
                value = $signed(a) >>> b[4:0];
            end else begin
                illegal = 1'b1;
            end
        end else if (opc == `OPC_OP_IMM) begin
            case (f3)
                3'd0: value = a + imm;
                3'd2: value = {31'b0, $signed(a) < $signed(imm)};
                3'd4: value = a ^ imm;
                3'd6: value = a | imm;
                3'd7: value = a & imm;
                default: illegal = 1'b1;
            endcase
        end else if (opc == `OPC_BRANCH) begin
            case (f3)
                3'd0, 3'd1, 3'd4, 3'd5: illegal = 1'b0;
                default: illegal = 1'b1;
            endcase
        end else begin
            illegal = 1'b1;
        end
    endfunction

    task automatic check_cpl(input string name, input cpl_t exp, input cpl_t got);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, got));
        end
    endtask

    task automatic check_redirect(input string name, input redirect_t exp, input redirect_t got);
        if (exp.valid) begin
            if (got !== exp) begin
                stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, got));
            end
        end else if (got.valid !== 1'b0) begin
            stop_on_error($sformatf("Unexpected redirect to %h in cycle %0d", got.target, cyc));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            stop_on_error($sformatf("Mismatch %s: expected %b, actual %b", name, exp, got));
        end
    endtask

    task automatic check_channel(input string chan, input string name,
                                 input cpl_t exp, input cpl_t got);
        if (!exp.valid && got.valid !== 1'b0) begin
            stop_on_error($sformatf("Unexpected %s completion for ROB tag %0d in cycle %0d",
                                    chan, got.rob_tag, cyc));
        end else if (exp.valid && got.valid !== 1'b1) begin
            stop_on_error($sformatf("Missing %s completion for %s in cycle %0d",
                                    chan, name, cyc));
        end else if (exp.valid) begin
            check_cpl(name, exp, got);
        end
    endtask

    // Compares everything due in the current cycle, then retires it
    task automatic check_cycle();
        cpl_t      exp_alu;
        cpl_t      exp_mul;
        redirect_t exp_rd;
        string     alu_name;
        string     mul_name;
        entry_t    keep[$];
        exp_alu = '0;
        exp_mul = '0;
        exp_rd = '0;
        alu_name = "idle";
        mul_name = "idle";
        foreach (pend[i]) begin
            if (pend[i].due == cyc && pend[i].on_mul) begin
                exp_mul = pend[i].cpl;
                mul_name = pend[i].name;
            end else if (pend[i].due == cyc) begin
                exp_alu = pend[i].cpl;
                exp_rd = pend[i].redir;
                alu_name = pend[i].name;
            end
        end
        check_channel("ALU", alu_name, exp_alu, alu_cpl);
        check_channel("MUL", mul_name, exp_mul, mul_cpl);
        check_redirect(alu_name, exp_rd, redirect);
        check_flag("rob_flush", last_redir == cyc - 1, rob_flush);
        if (exp_rd.valid) last_redir = cyc;
        foreach (pend[i]) begin
            if (pend[i].due > cyc) keep.push_back(pend[i]);
        end
        pend = keep;
    endtask

    task automatic issue_op(input case_t c, input int idx, input bit use_model);
        entry_t      e;
        logic [31:0] value;
        logic        illegal;
        logic        is_mul;
        logic [31:0] target;
        model_op(c.inst, c.pc, c.rs1, c.rs2, value, illegal, is_mul, target);
        issue.valid = 1'b1;
        issue.inst = c.inst;
        issue.pc = c.pc;
        issue.rob_tag = `ROB_TAG_W'(idx % 64);
        issue.prd = c.prd;
        issue.rs1_val = c.rs1;
        issue.rs2_val = c.rs2;
        if (cyc > squash_until) begin   // Ops in a taken branch's shadow never complete
            e.due = cyc + (is_mul ? `MUL_LAT : `ALU_LAT);
            e.on_mul = is_mul;
            e.cpl.valid = 1'b1;
            e.cpl.rob_tag = `ROB_TAG_W'(idx % 64);
            e.cpl.prd = c.prd;
            e.cpl.value = use_model ? value : c.value;
            e.cpl.illegal = illegal;
            e.redir.valid = c.redir;
            e.redir.target = target;
            e.name = c.name;
            pend.push_back(e);
            if (c.redir) squash_until = cyc + 4;
        end
    endtask

    function automatic logic [31:0] pick_reg_op(input int sel);
        case (sel)
            0: return 32'h002081b3;   // ADD
            1: return 32'h402081b3;   // SUB
            2: return 32'h0020f1b3;
            3: return 32'h0020e1b3;
            4: return 32'h0020c1b3;
            5: return 32'h0020a1b3;
            6: return 32'h002091b3;
            7: return 32'h0020d1b3;
            8: return 32'h4020d1b3;   // SRA
            default: return 32'h022081b3;   // MUL
        endcase
    endfunction

    task automatic load_cases();
        int    fd;
        int    rc;
        int    redir;
        string line;
        case_t c;
        fd = $fopen("bench/exec_slice_cases.txt", "r");
        if (fd == 0) stop_on_error("Cannot open bench/exec_slice_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            rc = $sscanf(line, "%h %h %h %h %h %h %d %s", c.inst, c.pc, c.rs1, c.rs2,
                         c.prd, c.value, redir, c.name);
            if (rc != 8) stop_on_error($sformatf("Bad line in case file: %s", line));
            c.redir = (redir != 0);
            cases.push_back(c);
        end
        $fclose(fd);
        cases_loaded = 1'b1;
    endtask

    initial begin
        case_t c;
        issue = '0;
        reset = 1'b1;
        load_cases();
        repeat (16) begin
            @(negedge clk);
            check_cpl("reset_alu", '0, alu_cpl);
            check_cpl("reset_mul", '0, mul_cpl);
            check_redirect("reset_redirect", '0, redirect);
            check_flag("reset_rob_flush", 1'b0, rob_flush);
        end
        reset = 1'b0;
        foreach (cases[i]) begin
            @(negedge clk);
            check_cycle();
            issue_op(cases[i], i, 1'b0);
        end
        for (int k = 0; k < 40; k++) begin
            @(negedge clk);
            check_cycle();
            rnd = xorshift(rnd);
            c.inst = pick_reg_op(int'(rnd % 32'd10));
            rnd = xorshift(rnd);
            c.rs1 = rnd;
            rnd = xorshift(rnd);
            c.rs2 = rnd;
            c.pc = 32'h1000 + 32'(4 * k);
            c.prd = 8'(k + 64);
            c.redir = 1'b0;
            c.name = $sformatf("rand_%0d", k);
            issue_op(c, cases.size() + k, 1'b1);
        end
        repeat (8) begin
            @(negedge clk);
            check_cycle();
            issue = '0;
        end
        if (pend.size() != 0) begin
            stop_on_error($sformatf("%0d completions never arrived", pend.size()));
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

    // Watchdog sized from the number of issued ops
    initial begin
        int limit_ns;
        wait (cases_loaded);
        @(negedge reset);
        limit_ns = (cases.size() + 40 + 20) * 4;
        #(limit_ns);
        stop_on_error($sformatf("Watchdog expired after %0d ns past reset", limit_ns));
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+logic
logic/core_pkg.sv
logic/ifid_stage.sv
logic/inst_decode.sv
logic/exec_unit.sv
logic/result_stage.sv
logic/exec_slice_top.sv
bench/exec_slice_tb.sv

/* Makefile */
# Verilator build and run for the execution slice testbench

TOP = exec_slice_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

# A $fatal in the testbench gives a failing exit status
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* bench/exec_slice_cases.txt */
# inst pc rs1_val rs2_val prd expected_value expected_redirect name
# hex fields except the redirect flag; lines in a branch shadow keep their unsquashed value
002081b3 00000100 00000005 00000007 10 0000000c 0 add_small
402081b3 00000104 00000005 00000007 11 fffffffe 0 sub_neg
0020f1b3 00000108 f0f0f0f0 0ff00ff0 12 00f000f0 0 and_reg
0020e1b3 0000010c f0f0f0f0 0ff00ff0 13 fff0fff0 0 or_reg
0020c1b3 00000110 f0f0f0f0 0ff00ff0 14 ff00ff00 0 xor_reg
0020a1b3 00000114 ffffffff 00000001 15 00000001 0 slt_neg
002091b3 00000118 00000001 0000003f 16 80000000 0 sll_mask
0020d1b3 0000011c 80000000 00000004 17 08000000 0 srl_4
4020d1b3 00000120 80000000 00000004 18 f8000000 0 sra_4
00508193 00000124 00000010 deadbeef 19 00000015 0 addi_pos
fff08193 00000128 00000000 deadbeef 1a ffffffff 0 addi_neg
0f00f193 0000012c 12345678 deadbeef 1b 00000070 0 andi
7ff0e193 00000130 80000000 deadbeef 1c 800007ff 0 ori
fff0c193 00000134 0000ffff deadbeef 1d ffff0000 0 xori_neg
00a0a193 00000138 fffffff6 deadbeef 1e 00000001 0 slti_neg
022081b3 0000013c 00000003 00000007 1f 00000015 0 mul_small
022081b3 00000140 ffffffff ffffffff 20 00000001 0 mul_neg
022081b3 00000144 00010001 00010001 21 00020001 0 mul_carry
002081b3 00000148 00000100 00000023 22 00000123 0 add_beside_mul
4020f1b3 0000014c 00000001 00000002 23 00000000 0 bad_funct7
0000a183 00000150 00000001 00000002 24 00000000 0 bad_opcode
00208863 00000200 00000001 00000002 25 00000000 0 beq_not_taken
022081b3 00000204 00000006 00000007 26 0000002a 0 mul_before_br
fe209ce3 00000300 00000001 00000002 27 00000000 1 bne_taken_back
002081b3 00000304 00000001 00000001 28 00000002 0 squash_add
022081b3 00000308 00000002 00000003 29 00000006 0 squash_mul
0020e1b3 0000030c 00000001 00000002 2a 00000003 0 squash_or
00508193 00000310 00000001 deadbeef 2b 00000006 0 squash_addi
002081b3 00000314 00000002 00000003 2c 00000005 0 add_after_flush
0020c863 00000400 fffffffb 00000003 2d 00000000 1 blt_taken
0020d863 00000404 00000005 00000003 2e 00000000 1 bge_in_shadow
022081b3 00000408 00000004 00000004 2f 00000010 0 squash_mul_2
402081b3 0000040c 00000009 00000001 30 00000008 0 squash_sub
0020c1b3 00000410 0000000f 000000f0 31 000000ff 0 squash_xor
0020d863 00000500 00000001 00000002 32 00000000 0 bge_not_taken
0020a863 00000504 00000001 00000002 33 00000000 0 bad_branch
